//--- hdl/mm_macros.svh
//**************************************************
// fixed 4x4 matrices of 32-bit elements
// one buffer row holds one matrix row
// one AXI burst carries one whole matrix
//**************************************************

`ifndef MM_MACROS_SVH
`define MM_MACROS_SVH

// element width in bits
`define MM_DW 32

// matrix and array dimension
`define MM_SA 4

// buffer row address width, log2 of MM_SA
`define MM_BUF_AW 2

// beats per matrix transfer
`define MM_BURST_LEN 16

`endif

//--- hdl/mm_pkg.sv
//**************************************************
// shared types of the matrix-multiply subsystem
// AXI channels carry only the fields in use here
//**************************************************

`include "mm_macros.svh"

package mm_pkg;

    typedef logic [`MM_DW-1:0] elem_t;
    typedef logic signed [2*`MM_DW:0] acc_t;
    typedef logic [`MM_SA*`MM_DW-1:0] buf_row_t;
    typedef logic [`MM_BUF_AW-1:0] buf_addr_t;
    typedef logic [31:0] axi_addr_t;
    typedef logic [0:0] axi_id_t;

    // read address channel
    typedef struct packed {
        logic      valid;
        axi_id_t   id;
        axi_addr_t addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_ar_t;

    // read data channel
    typedef struct packed {
        logic    valid;
        axi_id_t id;
        elem_t   data;
        logic    last;
    } axi_r_t;

    // write address channel
    typedef struct packed {
        logic      valid;
        axi_addr_t addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_aw_t;

    // write data channel
    typedef struct packed {
        logic               valid;
        elem_t              data;
        logic [`MM_DW/8-1:0] strb;
        logic               last;
    } axi_w_t;

    // write response channel
    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } axi_b_t;

    // one row write toward an operand buffer
    typedef struct packed {
        logic                          we;
        buf_addr_t                     addr;
        logic [`MM_SA*`MM_DW/8-1:0]    be;
        buf_row_t                      data;
    } buf_wr_t;

    // byte base addresses of A, B and C
    typedef struct packed {
        axi_addr_t a_addr;
        axi_addr_t b_addr;
        axi_addr_t c_addr;
    } dma_cfg_t;

    // element [i*MM_SA + j] is C[i][j]
    typedef acc_t [`MM_SA*`MM_SA-1:0] acc_matrix_t;

    typedef enum logic [2:0] {
        DMA_IDLE,
        DMA_ADDR_AB,
        DMA_LOAD,
        DMA_WAIT_MM,
        DMA_ADDR_C,
        DMA_WRITE_C,
        DMA_WAIT_B
    } dma_state_t;

    typedef enum logic [1:0] {
        MM_IDLE,
        MM_RUN,
        MM_DRAIN
    } mm_state_t;

endpackage

//--- hdl/operand_buffer.sv
//**************************************************
// one matrix, one row per address
// write and read both take one cycle
// storage is not cleared by reset
//**************************************************

`include "mm_macros.svh"

module operand_buffer (
    input  logic              clk,
    input  mm_pkg::buf_wr_t   wr_i,
    input  mm_pkg::buf_addr_t raddr_i,
    output mm_pkg::buf_row_t  rdata_o
);
    import mm_pkg::*;

    localparam int DEPTH = 1 << `MM_BUF_AW;
    localparam int N_BYTE = $bits(buf_row_t) / 8;

    buf_row_t mem_q [DEPTH];
    buf_row_t rdata_q;

    // byte-enabled write
    always_ff @(posedge clk) begin
        if (wr_i.we) begin
            for (int b = 0; b < N_BYTE; b++) begin
                if (wr_i.be[b]) begin
                    mem_q[wr_i.addr][b*8 +: 8] <= wr_i.data[b*8 +: 8];
                end
            end
        end
    end

    // read data one cycle after the address
    always_ff @(posedge clk) begin
        rdata_q <= mem_q[raddr_i];
    end

    assign rdata_o = rdata_q;

endmodule

//--- hdl/mm_engine.sv
//**************************************************
// C = A * B over signed 32-bit elements
// done comes 18 cycles after start
// accum_o holds from done until the next start
//**************************************************

`include "mm_macros.svh"

module mm_engine (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_i,
    output logic                done_o,
    output mm_pkg::buf_addr_t   raddr_o,
    input  mm_pkg::buf_row_t    a_row_i,
    input  mm_pkg::buf_row_t    b_row_i,
    output mm_pkg::acc_matrix_t accum_o
);
    import mm_pkg::*;

    localparam int N_ELEM = `MM_SA * `MM_SA;
    localparam int STEP_W = 2 * `MM_BUF_AW;
    localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(N_ELEM - 1);

    mm_state_t state_q;
    // i in the upper half, k in the lower half
    logic [STEP_W-1:0] step_q;
    logic [STEP_W-1:0] rd_step_q;
    logic rd_vld_q;
    logic done_q;

    buf_row_t a_cache_q [`MM_SA];
    acc_t acc_q [N_ELEM];

    buf_addr_t ret_i;
    buf_addr_t ret_k;
    buf_row_t a_src;
    logic signed [`MM_DW-1:0] a_elem;
    logic signed [`MM_DW-1:0] b_elem [`MM_SA];
    logic signed [2*`MM_DW-1:0] prod [`MM_SA];

    // both buffers see the same row address k
    assign raddr_o = step_q[`MM_BUF_AW-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= MM_IDLE;
            step_q <= '0;
            rd_vld_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            rd_vld_q <= (state_q == MM_RUN);
            done_q <= (state_q == MM_DRAIN);
            case (state_q)
                MM_IDLE: begin
                    if (start_i) begin
                        state_q <= MM_RUN;
                        step_q <= '0;
                    end
                end
                MM_RUN: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == STEP_LAST) begin
                        state_q <= MM_DRAIN;
                    end
                end
                MM_DRAIN: state_q <= MM_IDLE;
                default:  state_q <= MM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        rd_step_q <= step_q;
    end

    assign ret_i = rd_step_q[STEP_W-1:`MM_BUF_AW];
    assign ret_k = rd_step_q[`MM_BUF_AW-1:0];

    // A row i comes back live when k == i, otherwise from the copy
    // kept since the first pass over k
    always_comb begin
        a_src = (ret_i == ret_k) ? a_row_i : a_cache_q[ret_i];
        a_elem = a_src[ret_k*`MM_DW +: `MM_DW];
        for (int j = 0; j < `MM_SA; j++) begin
            b_elem[j] = b_row_i[j*`MM_DW +: `MM_DW];
            prod[j] = a_elem * b_elem[j];
        end
    end

    always_ff @(posedge clk) begin
        if (rd_vld_q) begin
            a_cache_q[ret_k] <= a_row_i;
        end
    end

    // row i of C, all four columns at once
    always_ff @(posedge clk) begin
        if (state_q == MM_IDLE && start_i) begin
            for (int n = 0; n < N_ELEM; n++) begin
                acc_q[n] <= '0;
            end
        end else if (rd_vld_q) begin
            for (int j = 0; j < `MM_SA; j++) begin
                acc_q[ret_i*`MM_SA + j] <= acc_q[ret_i*`MM_SA + j] + prod[j];
            end
        end
    end

    always_comb begin
        for (int n = 0; n < N_ELEM; n++) begin
            accum_o[n] = acc_q[n];
        end
    end

    assign done_o = done_q;

    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> state_q == MM_IDLE);

endmodule

//--- hdl/dma_engine.sv
//**************************************************
// reads A (ID 0) and B (ID 1) as two INCR bursts
// writes low 32 bits of C as one 16-beat burst
// response codes are not checked
// start_i is ignored unless idle
//**************************************************

`include "mm_macros.svh"

module dma_engine (
    input  logic                clk,
    input  logic                rst_n,
    input  mm_pkg::dma_cfg_t    cfg_i,
    input  logic                start_i,
    output logic                done_o,
    output mm_pkg::axi_ar_t     ar_o,
    input  logic                ar_ready_i,
    input  mm_pkg::axi_r_t      r_i,
    output logic                r_ready_o,
    output mm_pkg::axi_aw_t     aw_o,
    input  logic                aw_ready_i,
    output mm_pkg::axi_w_t      w_o,
    input  logic                w_ready_i,
    input  mm_pkg::axi_b_t      b_i,
    output logic                b_ready_o,
    output mm_pkg::buf_wr_t     buf_a_wr_o,
    output mm_pkg::buf_wr_t     buf_b_wr_o,
    output logic                mm_start_o,
    input  logic                mm_done_i,
    input  mm_pkg::acc_matrix_t accum_i
);
    import mm_pkg::*;

    localparam int N_ID = 2;
    localparam int LANE_W = $clog2(`MM_SA);
    localparam int WCNT_W = $clog2(`MM_BURST_LEN);
    localparam logic [LANE_W-1:0] LANE_LAST = LANE_W'(`MM_SA - 1);
    localparam logic [WCNT_W-1:0] W_LAST = WCNT_W'(`MM_BURST_LEN - 1);
    localparam logic [7:0] AXI_LEN = 8'(`MM_BURST_LEN - 1);
    localparam logic [2:0] AXI_SIZE = 3'($clog2(`MM_DW / 8));
    localparam logic [1:0] AXI_INCR = 2'b01;

    dma_state_t state_q;
    dma_state_t state_d;
    dma_cfg_t cfg_q;
    axi_id_t ar_sel_q;
    logic [WCNT_W-1:0] wcnt_q;
    logic mm_start_q;
    logic done_q;

    // per-ID packing state, index is the AXI ID
    logic [LANE_W-1:0] lane_q [N_ID];
    buf_addr_t row_q [N_ID];
    buf_row_t pack_q [N_ID];
    logic [N_ID-1:0] wr_q;
    logic [N_ID-1:0] last_q;

    logic start_ok;
    logic r_fire;
    logic w_fire;
    logic load_done;

    assign start_ok = (state_q == DMA_IDLE) && start_i;
    assign r_fire = r_i.valid && r_ready_o;
    assign w_fire = w_o.valid && w_ready_i;
    // both bursts ended and their last rows already written
    assign load_done = (&last_q) && !(|wr_q);

    always_comb begin
        state_d = state_q;
        case (state_q)
            DMA_IDLE:    if (start_i) state_d = DMA_ADDR_AB;
            DMA_ADDR_AB: if (ar_ready_i && ar_sel_q == 1'b1) state_d = DMA_LOAD;
            DMA_LOAD:    if (load_done) state_d = DMA_WAIT_MM;
            DMA_WAIT_MM: if (mm_done_i) state_d = DMA_ADDR_C;
            DMA_ADDR_C:  if (aw_ready_i) state_d = DMA_WRITE_C;
            DMA_WRITE_C: if (w_fire && w_o.last) state_d = DMA_WAIT_B;
            DMA_WAIT_B:  if (b_i.valid) state_d = DMA_IDLE;
            default:     state_d = DMA_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= DMA_IDLE;
            ar_sel_q <= '0;
            wcnt_q <= '0;
            mm_start_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            state_q <= state_d;
            mm_start_q <= (state_q == DMA_LOAD) && load_done;
            done_q <= (state_q == DMA_WAIT_B) && b_i.valid;
            if (start_ok) begin
                ar_sel_q <= '0;
                wcnt_q <= '0;
            end else begin
                // second AR goes out once the first is taken
                if (state_q == DMA_ADDR_AB && ar_ready_i) begin
                    ar_sel_q <= 1'b1;
                end
                if (w_fire) begin
                    wcnt_q <= wcnt_q + 1'b1;
                end
            end
        end
    end

    // base addresses held for the whole job
    always_ff @(posedge clk) begin
        if (start_ok) begin
            cfg_q <= cfg_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || start_ok) begin
            for (int id = 0; id < N_ID; id++) begin
                lane_q[id] <= '0;
                row_q[id] <= '0;
            end
            wr_q <= '0;
            last_q <= '0;
        end else begin
            for (int id = 0; id < N_ID; id++) begin
                wr_q[id] <= 1'b0;
                if (wr_q[id]) begin
                    row_q[id] <= row_q[id] + 1'b1;
                end
                if (r_fire && r_i.id == axi_id_t'(id)) begin
                    lane_q[id] <= lane_q[id] + 1'b1;
                    // full row, write it next cycle
                    if (lane_q[id] == LANE_LAST) begin
                        wr_q[id] <= 1'b1;
                    end
                    if (r_i.last) begin
                        last_q[id] <= 1'b1;
                    end
                end
            end
        end
    end

    // beat n lands in lane n mod 4
    always_ff @(posedge clk) begin
        if (r_fire) begin
            pack_q[r_i.id][lane_q[r_i.id]*`MM_DW +: `MM_DW] <= r_i.data;
        end
    end

    always_comb begin
        buf_a_wr_o.we = wr_q[0];
        buf_a_wr_o.addr = row_q[0];
        buf_a_wr_o.be = '1;
        buf_a_wr_o.data = pack_q[0];
        buf_b_wr_o.we = wr_q[1];
        buf_b_wr_o.addr = row_q[1];
        buf_b_wr_o.be = '1;
        buf_b_wr_o.data = pack_q[1];
    end

    always_comb begin
        ar_o.valid = (state_q == DMA_ADDR_AB);
        ar_o.id = ar_sel_q;
        ar_o.addr = ar_sel_q ? cfg_q.b_addr : cfg_q.a_addr;
        ar_o.len = AXI_LEN;
        ar_o.size = AXI_SIZE;
        ar_o.burst = AXI_INCR;

        aw_o.valid = (state_q == DMA_ADDR_C);
        aw_o.addr = cfg_q.c_addr;
        aw_o.len = AXI_LEN;
        aw_o.size = AXI_SIZE;
        aw_o.burst = AXI_INCR;

        // C goes out row-major, truncated to the element width
        w_o.valid = (state_q == DMA_WRITE_C);
        w_o.data = accum_i[wcnt_q][`MM_DW-1:0];
        w_o.strb = '1;
        w_o.last = (wcnt_q == W_LAST);
    end

    assign r_ready_o = (state_q == DMA_LOAD);
    assign b_ready_o = (state_q == DMA_WAIT_B);
    assign mm_start_o = mm_start_q;
    assign done_o = done_q;

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_o.valid && !ar_ready_i |=> ar_o.valid && $stable(ar_o));

    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        w_o.valid && !w_ready_i |=> w_o.valid && $stable(w_o));

    a_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mm_start_o |=> !mm_start_o);

endmodule

//--- hdl/mm_subsystem_top.sv
//**************************************************
// matrix-multiply subsystem, AXI master toward memory
// one job per start, done pulses after the B response
//**************************************************

module mm_subsystem_top (
    input  logic             clk,
    input  logic             rst_n,
    input  mm_pkg::dma_cfg_t cfg_i,
    input  logic             start_i,
    output logic             done_o,
    output mm_pkg::axi_ar_t  ar_o,
    input  logic             ar_ready_i,
    input  mm_pkg::axi_r_t   r_i,
    output logic             r_ready_o,
    output mm_pkg::axi_aw_t  aw_o,
    input  logic             aw_ready_i,
    output mm_pkg::axi_w_t   w_o,
    input  logic             w_ready_i,
    input  mm_pkg::axi_b_t   b_i,
    output logic             b_ready_o
);
    import mm_pkg::*;

    buf_wr_t buf_a_wr;
    buf_wr_t buf_b_wr;
    buf_addr_t mm_raddr;
    buf_row_t buf_a_row;
    buf_row_t buf_b_row;
    acc_matrix_t accum;
    logic mm_start;
    logic mm_done;

    dma_engine i_dma (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_i      (cfg_i),
        .start_i    (start_i),
        .done_o     (done_o),
        .ar_o       (ar_o),
        .ar_ready_i (ar_ready_i),
        .r_i        (r_i),
        .r_ready_o  (r_ready_o),
        .aw_o       (aw_o),
        .aw_ready_i (aw_ready_i),
        .w_o        (w_o),
        .w_ready_i  (w_ready_i),
        .b_i        (b_i),
        .b_ready_o  (b_ready_o),
        .buf_a_wr_o (buf_a_wr),
        .buf_b_wr_o (buf_b_wr),
        .mm_start_o (mm_start),
        .mm_done_i  (mm_done),
        .accum_i    (accum)
    );

    // matrix A
    operand_buffer i_buf_a (
        .clk     (clk),
        .wr_i    (buf_a_wr),
        .raddr_i (mm_raddr),
        .rdata_o (buf_a_row)
    );

    // matrix B
    operand_buffer i_buf_b (
        .clk     (clk),
        .wr_i    (buf_b_wr),
        .raddr_i (mm_raddr),
        .rdata_o (buf_b_row)
    );

    mm_engine i_mm (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (mm_start),
        .done_o  (mm_done),
        .raddr_o (mm_raddr),
        .a_row_i (buf_a_row),
        .b_row_i (buf_b_row),
        .accum_o (accum)
    );

endmodule

//--- sim/axi_mem_model.sv
//**************************************************
// behavioral AXI slave memory of 1024 words
// bursts are served in order, one at a time
// strobes are ignored, every response is OKAY
//**************************************************

module axi_mem_model (
    input  logic            clk,
    input  logic            rst_n,
    input  mm_pkg::axi_ar_t ar_i,
    output logic            ar_ready_o,
    output mm_pkg::axi_r_t  r_o,
    input  logic            r_ready_i,
    input  mm_pkg::axi_aw_t aw_i,
    output logic            aw_ready_o,
    input  mm_pkg::axi_w_t  w_i,
    output logic            w_ready_o,
    output mm_pkg::axi_b_t  b_o,
    input  logic            b_ready_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import mm_pkg::*;

    localparam int MEM_WORDS = 1024;

    // one accepted read burst waiting for its data beats
    typedef struct packed {
        logic [31:0] word;
        axi_id_t     id;
        logic [7:0]  len;
    } rd_req_t;

    logic [31:0] mem [MEM_WORDS];
    int seed = 32'hc670;
    int rnd;

    rd_req_t rd_q [$];
    rd_req_t rd_cur;
    logic rd_busy = 1'b0;
    int rd_cnt;
    int wr_word;
    int wr_cnt;
    logic wr_busy = 1'b0;
    logic b_pend = 1'b0;

    logic ar_ready_q = 1'b0;
    logic aw_ready_q = 1'b0;
    logic w_ready_q = 1'b0;
    axi_r_t r_q = '0;
    axi_b_t b_q = '0;

    assign ar_ready_o = ar_ready_q;
    assign aw_ready_o = aw_ready_q;
    assign w_ready_o = w_ready_q;
    assign r_o = r_q;
    assign b_o = b_q;

    always @(posedge clk) begin
        rnd = $random(seed);
        if (!rst_n) begin
            ar_ready_q <= 1'b0;
            aw_ready_q <= 1'b0;
            w_ready_q <= 1'b0;
            r_q <= '0;
            b_q <= '0;
            rd_busy <= 1'b0;
            wr_busy <= 1'b0;
            b_pend <= 1'b0;
            rd_q.delete();
        end else begin
            // ready stalls about one cycle in four
            ar_ready_q <= (rnd[1:0] != 2'b00);
            aw_ready_q <= (rnd[5:4] != 2'b00) && !wr_busy;
            w_ready_q <= (rnd[7:6] != 2'b00);
            if (ar_i.valid && ar_ready_q) begin
                rd_q.push_back(rd_req_t'{ar_i.addr >> 2, ar_i.id, ar_i.len});
            end
            if (r_q.valid && r_ready_i) begin
                r_q.valid <= 1'b0;
                if (r_q.last) begin
                    rd_busy <= 1'b0;
                end else begin
                    rd_cnt <= rd_cnt + 1;
                end
            end else if (!rd_busy && rd_q.size() > 0) begin
                rd_cur <= rd_q.pop_front();
                rd_cnt <= 0;
                rd_busy <= 1'b1;
            end else if (rd_busy && !r_q.valid && rnd[3:2] != 2'b00) begin
                r_q.valid <= 1'b1;
                r_q.id <= rd_cur.id;
                r_q.data <= mem[(int'(rd_cur.word) + rd_cnt) % MEM_WORDS];
                r_q.last <= (rd_cnt == int'(rd_cur.len));
            end
            if (aw_i.valid && aw_ready_q) begin
                wr_word <= int'(aw_i.addr >> 2);
                wr_cnt <= 0;
                wr_busy <= 1'b1;
            end
            if (w_i.valid && w_ready_q) begin
                mem[(wr_word + wr_cnt) % MEM_WORDS] = w_i.data;
                wr_cnt <= wr_cnt + 1;
                if (w_i.last) begin
                    wr_busy <= 1'b0;
                    b_pend <= 1'b1;
                end
            end
            if (b_q.valid && b_ready_i) begin
                b_q.valid <= 1'b0;
            end else if (b_pend && !b_q.valid && rnd[9:8] != 2'b00) begin
                b_q.valid <= 1'b1;
                b_q.resp <= 2'b00;
                b_pend <= 1'b0;
            end
        end
    end

endmodule

//--- sim/tb_mm_subsystem.sv
//**************************************************
// one full job per table row, memory stalls at random
// all base addresses must fall inside the 4 KB model
//**************************************************

`include "mm_macros.svh"

module tb_mm_subsystem;
    timeunit 1ns;
    timeprecision 1ps;
    import mm_pkg::*;

    localparam int N_ELEM = `MM_SA * `MM_SA;
    localparam int N_CASES = 4;
    localparam int DONE_TIMEOUT = 4000;
    localparam int QUIET_CYCLES = 30;
    localparam logic [7:0] EXP_LEN = 8'(`MM_BURST_LEN - 1);
    // 4-byte beats, full width only
    localparam logic [2:0] EXP_SIZE = 3'd2;
    localparam logic [3:0] EXP_STRB = 4'hf;

    // base addresses, fill seed, right shift applied to each element
    typedef struct packed {
        axi_addr_t   a_addr;
        axi_addr_t   b_addr;
        axi_addr_t   c_addr;
        logic [31:0] fill_seed;
        logic [4:0]  shift;
    } case_t;

    case_t cases [N_CASES] = '{
        '{32'h0000_0000, 32'h0000_0040, 32'h0000_0080, 32'h0000_1234, 5'd24},
        '{32'h0000_0400, 32'h0000_0800, 32'h0000_0c00, 32'h0000_beef, 5'd0},
        '{32'h0000_0f00, 32'h0000_0100, 32'h0000_0040, 32'h0000_0042, 5'd16},
        '{32'h0000_0200, 32'h0000_0a40, 32'h0000_0300, 32'h0000_7a11, 5'd8}
    };

    logic clk = 1'b0;
    logic rst_n;
    dma_cfg_t cfg;
    logic start;
    logic done;
    axi_ar_t ar;
    logic ar_ready;
    axi_r_t r;
    logic r_ready;
    axi_aw_t aw;
    logic aw_ready;
    axi_w_t w;
    logic w_ready;
    axi_b_t b;
    logic b_ready;

    elem_t a_m [N_ELEM];
    elem_t b_m [N_ELEM];
    elem_t c_exp [N_ELEM];
    dma_cfg_t exp_cfg;
    logic started;
    logic b_fire_d;
    int ar_cnt;
    int aw_cnt;
    int w_cnt;
    int done_cnt;

    always #5 clk = ~clk;

    mm_subsystem_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_i      (cfg),
        .start_i    (start),
        .done_o     (done),
        .ar_o       (ar),
        .ar_ready_i (ar_ready),
        .r_i        (r),
        .r_ready_o  (r_ready),
        .aw_o       (aw),
        .aw_ready_i (aw_ready),
        .w_o        (w),
        .w_ready_i  (w_ready),
        .b_i        (b),
        .b_ready_o  (b_ready)
    );

    axi_mem_model i_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .ar_i       (ar),
        .ar_ready_o (ar_ready),
        .r_o        (r),
        .r_ready_i  (r_ready),
        .aw_i       (aw),
        .aw_ready_o (aw_ready),
        .w_i        (w),
        .w_ready_o  (w_ready),
        .b_o        (b),
        .b_ready_i  (b_ready)
    );

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // A and B from the case seed, C region prefilled with its inverted address
    task automatic load_case(input case_t tc);
        int fseed;
        int v;
        fseed = tc.fill_seed;
        for (int n = 0; n < N_ELEM; n++) begin
            v = $random(fseed);
            a_m[n] = elem_t'(v >>> tc.shift);
            v = $random(fseed);
            b_m[n] = elem_t'(v >>> tc.shift);
        end
        for (int n = 0; n < N_ELEM; n++) begin
            i_mem.mem[(tc.a_addr >> 2) + n] = a_m[n];
            i_mem.mem[(tc.b_addr >> 2) + n] = b_m[n];
            i_mem.mem[(tc.c_addr >> 2) + n] = ~(tc.c_addr + 32'(4 * n));
        end
    endtask

    // signed sum over k, kept to the low 32 bits
    function automatic void compute_golden();
        longint sum;
        for (int i = 0; i < `MM_SA; i++) begin
            for (int j = 0; j < `MM_SA; j++) begin
                sum = 0;
                for (int k = 0; k < `MM_SA; k++) begin
                    sum += longint'($signed(a_m[i*`MM_SA + k]))
                        * longint'($signed(b_m[k*`MM_SA + j]));
                end
                c_exp[i*`MM_SA + j] = elem_t'(sum);
            end
        end
    endfunction

    task automatic check_ar();
        axi_addr_t exp_addr;
        exp_addr = (ar_cnt == 0) ? exp_cfg.a_addr : exp_cfg.b_addr;
        assert (ar_cnt < 2) else report_fail("more than two read bursts in one case");
        assert (ar.id == axi_id_t'(ar_cnt))
            else report_fail($sformatf("ERR ar_o.id got %h exp %h", ar.id, ar_cnt));
        assert (ar.addr == exp_addr)
            else report_fail($sformatf("ERR ar_o.addr got %h exp %h", ar.addr, exp_addr));
        assert (ar.len == EXP_LEN)
            else report_fail($sformatf("ERR ar_o.len got %h exp %h", ar.len, EXP_LEN));
        assert (ar.size == EXP_SIZE)
            else report_fail($sformatf("ERR ar_o.size got %h exp %h", ar.size, EXP_SIZE));
        assert (ar.burst == 2'b01)
            else report_fail($sformatf("ERR ar_o.burst got %h exp %h", ar.burst, 2'b01));
        ar_cnt++;
    endtask

    task automatic check_aw();
        assert (aw_cnt == 0) else report_fail("more than one write burst in one case");
        assert (aw.addr == exp_cfg.c_addr)
            else report_fail($sformatf("ERR aw_o.addr got %h exp %h", aw.addr, exp_cfg.c_addr));
        assert (aw.len == EXP_LEN)
            else report_fail($sformatf("ERR aw_o.len got %h exp %h", aw.len, EXP_LEN));
        assert (aw.size == EXP_SIZE)
            else report_fail($sformatf("ERR aw_o.size got %h exp %h", aw.size, EXP_SIZE));
        assert (aw.burst == 2'b01)
            else report_fail($sformatf("ERR aw_o.burst got %h exp %h", aw.burst, 2'b01));
        aw_cnt++;
    endtask

    task automatic check_w();
        logic exp_last;
        exp_last = (w_cnt == `MM_BURST_LEN - 1);
        assert (w_cnt < `MM_BURST_LEN) else report_fail("write burst longer than 16 beats");
        assert (w.last == exp_last)
            else report_fail($sformatf("ERR w_o.last got %h exp %h", w.last, exp_last));
        assert (w.strb == EXP_STRB)
            else report_fail($sformatf("ERR w_o.strb got %h exp %h", w.strb, EXP_STRB));
        w_cnt++;
    endtask

    // handshake monitor sampling values settled in the previous cycle
    always @(posedge clk) begin
        if (rst_n) begin
            if (!started) begin
                assert (!ar.valid && !aw.valid && !w.valid && !done && !r_ready && !b_ready)
                    else report_fail("valid, ready or done_o raised before the first start");
            end
            // done exactly one cycle after the B handshake
            assert (done == b_fire_d)
                else report_fail($sformatf("ERR done_o got %h exp %h", done, b_fire_d));
            if (done) begin
                done_cnt++;
            end
            b_fire_d = b.valid && b_ready;
            if (ar.valid && ar_ready) begin
                check_ar();
            end
            if (aw.valid && aw_ready) begin
                check_aw();
            end
            if (w.valid && w_ready) begin
                check_w();
            end
        end else begin
            b_fire_d = 1'b0;
        end
    end

    task automatic run_case(input int t);
        int n;
        elem_t got;
        load_case(cases[t]);
        compute_golden();
        exp_cfg = '{cases[t].a_addr, cases[t].b_addr, cases[t].c_addr};
        ar_cnt = 0;
        aw_cnt = 0;
        w_cnt = 0;
        done_cnt = 0;
        cfg = exp_cfg;
        start = 1'b1;
        started = 1'b1;
        wait_cycles(1);
        start = 1'b0;
        // odd cases retry start mid-job with other addresses
        if (t % 2 == 1) begin
            wait_cycles(20);
            cfg = ~exp_cfg;
            start = 1'b1;
            wait_cycles(1);
            start = 1'b0;
            cfg = exp_cfg;
        end
        n = 0;
        while (done_cnt == 0 && n < DONE_TIMEOUT) begin
            wait_cycles(1);
            n++;
        end
        assert (done_cnt != 0) else report_fail("timeout waiting for done_o");
        wait_cycles(QUIET_CYCLES);
        assert (ar_cnt == 2) else report_fail($sformatf("ERR ar count got %h exp %h", ar_cnt, 2));
        assert (aw_cnt == 1) else report_fail($sformatf("ERR aw count got %h exp %h", aw_cnt, 1));
        assert (w_cnt == `MM_BURST_LEN)
            else report_fail($sformatf("ERR w count got %h exp %h", w_cnt, `MM_BURST_LEN));
        assert (done_cnt == 1)
            else report_fail($sformatf("ERR done_o count got %h exp %h", done_cnt, 1));
        for (int e = 0; e < N_ELEM; e++) begin
            got = i_mem.mem[(exp_cfg.c_addr >> 2) + e];
            assert (got == c_exp[e])
                else report_fail($sformatf("ERR mem C[%0d] got %h exp %h", e, got, c_exp[e]));
        end
    endtask

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        cfg = '0;
        exp_cfg = '0;
        started = 1'b0;
        b_fire_d = 1'b0;
        ar_cnt = 0;
        aw_cnt = 0;
        w_cnt = 0;
        done_cnt = 0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // outputs must stay quiet before any start
        wait_cycles(QUIET_CYCLES);
        for (int t = 0; t < N_CASES; t++) begin
            run_case(t);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+hdl
hdl/mm_pkg.sv
hdl/operand_buffer.sv
hdl/mm_engine.sv
hdl/dma_engine.sv
hdl/mm_subsystem_top.sv
sim/axi_mem_model.sv
sim/tb_mm_subsystem.sv

//--- Makefile
# Verilator build and run of the matrix-multiply subsystem testbench

SIM = obj_dir/Vtb_mm_subsystem

.PHONY: all run lint clean

all: run

$(SIM): flist.f $(wildcard hdl/*.sv hdl/*.svh sim/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mm_subsystem -f flist.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TEST PASSED" sim.log

lint:
	verilator --lint-only -Wall --assert --top-module mm_subsystem_top +incdir+hdl \
		hdl/mm_pkg.sv hdl/operand_buffer.sv hdl/mm_engine.sv hdl/dma_engine.sv \
		hdl/mm_subsystem_top.sv

clean:
	rm -rf obj_dir sim.log
